//--- common/isaPkg.sv
`default_nettype none

package isaPkg;

  localparam int opcodeWidth = 6;
  localparam int functWidth = 6;

  typedef logic [opcodeWidth-1:0] opcode_t;
  typedef logic [functWidth-1:0] funct_t;

  // Opcodes
  localparam opcode_t opRType = 6'h00;
  localparam opcode_t opJump = 6'h02;

  // R-type funct field
  localparam funct_t fnAdd = 6'h20;
  localparam funct_t fnAnd = 6'h24;
  localparam funct_t fnSub = 6'h22;
  localparam funct_t fnSlt = 6'h2A;
  localparam funct_t fnSllv = 6'h04;
  localparam funct_t fnSrav = 6'h07;
  localparam funct_t fnSll = 6'h00;
  localparam funct_t fnSra = 6'h03;
  localparam funct_t fnSrl = 6'h02;
  localparam funct_t fnJr = 6'h08;
  localparam funct_t fnMfhi = 6'h10;
  localparam funct_t fnMflo = 6'h12;
  localparam funct_t fnBreak = 6'h0D;
  localparam funct_t fnRte = 6'h13;

  // Full ALU control code set, branch and lui codes kept for the datapath
  typedef enum logic [3:0] {
    aluPassA = 4'd0,  // Also the idle code
    aluAdd = 4'd1,
    aluSub = 4'd2,
    aluAnd = 4'd3,
    aluPassB = 4'd4,
    aluShiftL1 = 4'd5,  // Shift by shamt
    aluShiftL2 = 4'd6,  // Shift by rs
    aluShiftR = 4'd7,
    aluShiftRa1 = 4'd8,
    aluShiftRa2 = 4'd9,
    aluSlt = 4'd10,
    aluBeq = 4'd11,
    aluBne = 4'd12,
    aluBle = 4'd13,
    aluBgt = 4'd14,
    aluLui = 4'd15
  } aluOp_t;

endpackage

`default_nettype wire

//--- common/controlPkg.sv
`default_nettype none

package controlPkg;

  localparam int stepWidth = 3;
  localparam int muxSelWidth = 2;
  localparam int writeDataSelWidth = 3;

  typedef logic [stepWidth-1:0] step_t;

  // Last step of the shared fetch sequence
  localparam step_t fetchLastStep = 3'd2;

  typedef enum logic [1:0] {
    resetPhase,
    fetchPhase,
    executePhase
  } phase_t;

  typedef enum logic [3:0] {
    aluReg,      // add, and, sub, slt
    shiftVar,    // sllv, srav
    shiftImm,    // sll, sra, srl
    jumpReg,
    returnExc,
    moveHiLo,
    breakInstr,
    jump,
    noOp         // Anything unsupported
  } instrClass_t;

  // PC input mux
  typedef enum logic [muxSelWidth-1:0] {
    pcSrcAluResult = 2'd0,
    pcSrcAluOut = 2'd1,
    pcSrcJumpTarget = 2'd2,
    pcSrcEpc = 2'd3
  } pcSource_t;

  typedef enum logic [muxSelWidth-1:0] {srcAPc = 2'd0, srcARegA = 2'd1} aluSrcA_t;
  typedef enum logic [muxSelWidth-1:0] {srcBRegB = 2'd0, srcBFour = 2'd1} aluSrcB_t;

  // Register file write address
  typedef enum logic [muxSelWidth-1:0] {
    regDstRt = 2'd0,
    regDstRd = 2'd1,
    regDstRa = 2'd3
  } regDst_t;

  typedef enum logic [writeDataSelWidth-1:0] {
    wdAluOut = 3'd0,
    wdHi = 3'd3,
    wdLo = 3'd4
  } writeData_t;

endpackage

`default_nettype wire

//--- common/decodeIf.sv
`timescale 1ns/1ps
`default_nettype none

interface decodeIf;
  import isaPkg::*;
  import controlPkg::*;

  instrClass_t instrClass;
  aluOp_t aluOp;  // Operation for the execute phase
  step_t execLastStep;
  logic hasExecute;
  logic [writeDataSelWidth-1:0] writeDataSel;

  modport decoder (
    output instrClass, aluOp, execLastStep, hasExecute, writeDataSel
  );
  modport sequencer (input hasExecute);
  modport counter (input execLastStep);
  modport encoder (input instrClass, aluOp, writeDataSel);

endinterface

`default_nettype wire

//--- hdl/instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
  input logic clk,
  input logic reset_in,
  input isaPkg::opcode_t opcode,
  input isaPkg::funct_t funct,
  input logic decodeNow,
  decodeIf.decoder decoded
);
  import isaPkg::*;
  import controlPkg::*;

  opcode_t opcodeHeld;
  funct_t functHeld;
  opcode_t opcodeSel;
  funct_t functSel;
  instrClass_t classSel;
  instrClass_t classHeld;

  function automatic instrClass_t classify(input opcode_t op, input funct_t fn);
    instrClass_t result;
    result = noOp;
    if (op == opJump) begin
      result = jump;
    end else if (op == opRType) begin
      case (fn)
        fnAdd, fnAnd, fnSub, fnSlt: result = aluReg;
        fnSllv, fnSrav: result = shiftVar;
        fnSll, fnSra, fnSrl: result = shiftImm;
        fnJr: result = jumpReg;
        fnRte: result = returnExc;
        fnMfhi, fnMflo: result = moveHiLo;
        fnBreak: result = breakInstr;
        default: result = noOp;
      endcase
    end
    return result;
  endfunction

  always_ff @(posedge clk) begin
    if (reset_in) begin
      opcodeHeld <= '1;  // Decodes as noOp
      functHeld <= '0;
    end else if (decodeNow) begin
      opcodeHeld <= opcode;
      functHeld <= funct;
    end
  end

  // Live fields during the latch cycle so fetch step 2 sees the new instruction
  assign opcodeSel = decodeNow ? opcode : opcodeHeld;
  assign functSel = decodeNow ? funct : functHeld;

  assign classSel = classify(opcodeSel, functSel);
  assign classHeld = classify(opcodeHeld, functHeld);

  assign decoded.instrClass = classSel;
  assign decoded.hasExecute = !(classSel inside {jump, noOp});

  always_comb begin
    case (functSel)
      fnAdd: decoded.aluOp = aluAdd;
      fnAnd: decoded.aluOp = aluAnd;
      fnSub, fnBreak: decoded.aluOp = aluSub;  // break computes pc - 4
      fnSlt: decoded.aluOp = aluSlt;
      fnSllv: decoded.aluOp = aluShiftL2;
      fnSrav: decoded.aluOp = aluShiftRa2;
      fnSll: decoded.aluOp = aluShiftL1;
      fnSra: decoded.aluOp = aluShiftRa1;
      fnSrl: decoded.aluOp = aluShiftR;
      default: decoded.aluOp = aluPassA;
    endcase
  end

  always_comb begin
    if (classSel == moveHiLo) begin
      decoded.writeDataSel = (functSel == fnMfhi) ? wdHi : wdLo;
    end else begin
      decoded.writeDataSel = wdAluOut;
    end
  end

  // Execute length minus one, from the held copy only
  always_comb begin
    case (classHeld)
      aluReg, shiftImm, jumpReg, breakInstr: decoded.execLastStep = 3'd4;
      shiftVar: decoded.execLastStep = 3'd5;  // Shifter takes an extra cycle
      returnExc, moveHiLo: decoded.execLastStep = 3'd1;
      default: decoded.execLastStep = 3'd0;
    endcase
  end

endmodule

`default_nettype wire

//--- sequencer/stepCounter.sv
`timescale 1ns/1ps
`default_nettype none

module stepCounter (
  input logic clk,
  input logic reset_in,
  input controlPkg::phase_t phase,
  decodeIf.counter decoded,
  output controlPkg::step_t step,
  output logic lastStep
);
  import controlPkg::*;

  always_comb begin
    case (phase)
      fetchPhase: lastStep = (step == fetchLastStep);
      executePhase: lastStep = (step == decoded.execLastStep);
      default: lastStep = 1'b1;  // Reset lasts a single cycle
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_in || lastStep) begin
      step <= '0;
    end else begin
      step <= step + 3'd1;
    end
  end

endmodule

`default_nettype wire

//--- sequencer/cycleSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module cycleSequencer (
  input logic clk,
  input logic reset_in,
  input logic lastStep,
  decodeIf.sequencer decoded,
  output controlPkg::phase_t phase,
  output logic decodeNow
);
  import controlPkg::*;

  always_ff @(posedge clk) begin
    if (reset_in) begin
      phase <= resetPhase;
    end else if (lastStep) begin
      case (phase)
        resetPhase: phase <= fetchPhase;
        fetchPhase: begin
          // j and unknown codes start the next fetch right away
          phase <= decoded.hasExecute ? executePhase : fetchPhase;
        end
        default: phase <= fetchPhase;
      endcase
    end
  end

  // Opcode and funct are latched as fetch ends
  assign decodeNow = (phase == fetchPhase) && lastStep;

endmodule

`default_nettype wire

//--- hdl/controlEncoder.sv
`timescale 1ns/1ps
`default_nettype none

module controlEncoder (
  input logic clk,
  input logic reset_in,
  input controlPkg::phase_t phase,
  input controlPkg::step_t step,
  decodeIf.encoder decoded,
  output logic resetOut,
  output logic pcWrite,
  output logic irWrite,
  output logic aluOutWrite,
  output logic regFileWrite,
  output logic aRegWrite,
  output logic bRegWrite,
  output logic [controlPkg::muxSelWidth-1:0] pcSource,
  output logic [controlPkg::muxSelWidth-1:0] aluSrcA,
  output logic [controlPkg::muxSelWidth-1:0] aluSrcB,
  output logic [controlPkg::muxSelWidth-1:0] regDst,
  output logic [controlPkg::writeDataSelWidth-1:0] writeDataSel,
  output isaPkg::aluOp_t aluOp
);
  import isaPkg::*;
  import controlPkg::*;

  always_ff @(posedge clk) begin
    // Every control idles unless the current step asks for it
    pcWrite <= 1'b0;
    irWrite <= 1'b0;
    aluOutWrite <= 1'b0;
    regFileWrite <= 1'b0;
    aRegWrite <= 1'b0;
    bRegWrite <= 1'b0;
    pcSource <= pcSrcAluResult;
    aluSrcA <= srcAPc;
    aluSrcB <= srcBRegB;
    regDst <= regDstRt;
    writeDataSel <= wdAluOut;
    aluOp <= aluPassA;
    if (reset_in) begin
      resetOut <= 1'b1;
    end else begin
      resetOut <= 1'b0;
      case (phase)
        fetchPhase: begin
          case (step)
            3'd0: begin  // IR load and pc + 4
              irWrite <= 1'b1;
              aluOutWrite <= 1'b1;
              aluSrcA <= srcAPc;
              aluSrcB <= srcBFour;
              aluOp <= aluAdd;
              pcSource <= pcSrcAluOut;
            end
            3'd2: begin
              pcWrite <= 1'b1;
              pcSource <= (decoded.instrClass == jump) ? pcSrcJumpTarget : pcSrcAluOut;
              if (decoded.instrClass == moveHiLo) begin
                regFileWrite <= 1'b1;
                regDst <= regDstRd;
                writeDataSel <= decoded.writeDataSel;
              end
            end
            default: ;  // Memory read in flight
          endcase
        end
        executePhase: begin
          case (decoded.instrClass)
            aluReg, shiftImm: begin
              if (step == 3'd0) begin
                aRegWrite <= (decoded.instrClass == aluReg);  // Shamt needs no rs
                bRegWrite <= 1'b1;
              end
              if (step == 3'd1) begin
                aluSrcA <= srcARegA;
                aluSrcB <= srcBRegB;
                aluOp <= decoded.aluOp;
                aluOutWrite <= 1'b1;
              end
              if (step == 3'd2) begin
                regFileWrite <= 1'b1;
                regDst <= regDstRd;
                writeDataSel <= decoded.writeDataSel;
              end
            end
            shiftVar: begin
              if (step == 3'd0) begin
                aRegWrite <= 1'b1;
                bRegWrite <= 1'b1;
              end
              // Two-cycle shifter, result captured on the second
              if (step == 3'd1 || step == 3'd2) begin
                aluSrcA <= srcARegA;
                aluSrcB <= srcBRegB;
                aluOp <= decoded.aluOp;
                aluOutWrite <= (step == 3'd2);
              end
              if (step == 3'd3) begin
                regFileWrite <= 1'b1;
                regDst <= regDstRd;
                writeDataSel <= decoded.writeDataSel;
              end
            end
            jumpReg: begin
              aRegWrite <= (step == 3'd0);
              if (step == 3'd1 || step == 3'd2) begin  // rs passed straight to pc
                aluSrcA <= srcARegA;
                aluOp <= aluPassA;
              end
              if (step == 3'd2) begin
                pcWrite <= 1'b1;
                pcSource <= pcSrcAluResult;
              end
            end
            returnExc: begin
              if (step == 3'd0) begin
                pcWrite <= 1'b1;
                pcSource <= pcSrcEpc;
              end
            end
            breakInstr: begin
              if (step == 3'd0) begin  // Undo the fetch increment
                aluSrcA <= srcAPc;
                aluSrcB <= srcBFour;
                aluOp <= decoded.aluOp;
                aluOutWrite <= 1'b1;
              end
              if (step == 3'd2) begin
                pcWrite <= 1'b1;
                pcSource <= pcSrcAluOut;
              end
            end
            default: ;  // moveHiLo waits for the write
          endcase
        end
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hdl/controlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
  input logic clk,
  input logic reset_in,
  input isaPkg::opcode_t opcode,
  input isaPkg::funct_t funct,
  output logic resetOut,
  output logic pcWrite,
  output logic irWrite,
  output logic aluOutWrite,
  output logic regFileWrite,
  output logic aRegWrite,
  output logic bRegWrite,
  output logic [controlPkg::muxSelWidth-1:0] pcSource,
  output logic [controlPkg::muxSelWidth-1:0] aluSrcA,
  output logic [controlPkg::muxSelWidth-1:0] aluSrcB,
  output logic [controlPkg::muxSelWidth-1:0] regDst,
  output logic [controlPkg::writeDataSelWidth-1:0] writeDataSel,
  output isaPkg::aluOp_t aluOp
);
  import controlPkg::*;

  phase_t phase;
  step_t step;
  logic lastStep;
  logic decodeNow;

  decodeIf decodeBus ();

  instrDecoder decoder (
    .clk(clk),
    .reset_in(reset_in),
    .opcode(opcode),
    .funct(funct),
    .decodeNow(decodeNow),
    .decoded(decodeBus.decoder)
  );

  stepCounter counter (
    .clk(clk),
    .reset_in(reset_in),
    .phase(phase),
    .decoded(decodeBus.counter),
    .step(step),
    .lastStep(lastStep)
  );

  cycleSequencer sequencer (
    .clk(clk),
    .reset_in(reset_in),
    .lastStep(lastStep),
    .decoded(decodeBus.sequencer),
    .phase(phase),
    .decodeNow(decodeNow)
  );

  controlEncoder encoder (
    .clk(clk),
    .reset_in(reset_in),
    .phase(phase),
    .step(step),
    .decoded(decodeBus.encoder),
    .resetOut(resetOut),
    .pcWrite(pcWrite),
    .irWrite(irWrite),
    .aluOutWrite(aluOutWrite),
    .regFileWrite(regFileWrite),
    .aRegWrite(aRegWrite),
    .bRegWrite(bRegWrite),
    .pcSource(pcSource),
    .aluSrcA(aluSrcA),
    .aluSrcB(aluSrcB),
    .regDst(regDst),
    .writeDataSel(writeDataSel),
    .aluOp(aluOp)
  );

endmodule

`default_nettype wire

//--- verif/controlUnitProperties.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnitProperties (
  input logic clk,
  input logic reset_in,
  input logic pcWrite,
  input logic irWrite,
  input logic aluOutWrite,
  input logic regFileWrite,
  input logic aRegWrite,
  input logic bRegWrite,
  input logic [2:0] writeDataSel
);

  logic anyWrite;

  assign anyWrite = pcWrite || irWrite || aluOutWrite || regFileWrite || aRegWrite
                    || bRegWrite;

  // IR load lasts one cycle
  irWritePulse: assert property (@(posedge clk) disable iff (reset_in)
    irWrite |=> !irWrite)
  else $error("irWrite held for more than one cycle");

  // Registered outputs, so idle one edge after reset is seen
  idleInReset: assert property (@(posedge clk) reset_in |=> !anyWrite)
  else $error("control write strobe high during reset");

  // Only mfhi and mflo share the fetch pc update cycle
  noWriteOverlap: assert property (@(posedge clk) disable iff (reset_in)
    (regFileWrite && pcWrite) |-> (writeDataSel == 3'd3 || writeDataSel == 3'd4))
  else $error("regFileWrite and pcWrite overlap");

endmodule

bind controlUnit controlUnitProperties checks (
  .clk(clk),
  .reset_in(reset_in),
  .pcWrite(pcWrite),
  .irWrite(irWrite),
  .aluOutWrite(aluOutWrite),
  .regFileWrite(regFileWrite),
  .aRegWrite(aRegWrite),
  .bRegWrite(bRegWrite),
  .writeDataSel(writeDataSel)
);

`default_nettype wire

//--- verif/controlUnitTb.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnitTb;

  localparam int numTests = 60;
  localparam logic [31:0] lfsrSeed = 32'hef0d52b2;

  // Expected behavior of one instruction in cycles from its irWrite pulse
  typedef struct packed {
    int len;              // Execute cycles
    int aluR;             // Cycle whose aluOp is checked or -1
    logic [3:0] aluOp;
    int regR;             // Cycle of regFileWrite or -1
    logic [2:0] wds;
    int pcR;              // Cycle of the last pcWrite
    logic [1:0] pcSrc;
  } trace_t;

  logic clk;
  logic reset_in;
  logic [5:0] opcode;
  logic [5:0] funct;
  logic resetOut, pcWrite, irWrite, aluOutWrite, regFileWrite, aRegWrite, bRegWrite;
  logic [1:0] pcSource, aluSrcA, aluSrcB, regDst;
  logic [2:0] writeDataSel;
  logic [3:0] aluOp;

  logic [31:0] lfsr;
  int failCount = 0;
  int testCount = 0;
  logic checksDone = 1'b0;

  controlUnit uut (
    .clk(clk), .reset_in(reset_in), .opcode(opcode), .funct(funct),
    .resetOut(resetOut), .pcWrite(pcWrite), .irWrite(irWrite),
    .aluOutWrite(aluOutWrite), .regFileWrite(regFileWrite),
    .aRegWrite(aRegWrite), .bRegWrite(bRegWrite), .pcSource(pcSource),
    .aluSrcA(aluSrcA), .aluSrcB(aluSrcB), .regDst(regDst),
    .writeDataSel(writeDataSel), .aluOp(aluOp)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic logic [31:0] takeBits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsrNext(lfsr);
      val = {val[30:0], lfsr[0]};
    end
    return val;
  endfunction

  // {opcode, funct}; last two entries are unsupported codes
  function automatic logic [11:0] pickInstr(input int idx);
    case (idx)
      0: return {6'h00, 6'h20};
      1: return {6'h00, 6'h24};
      2: return {6'h00, 6'h22};
      3: return {6'h00, 6'h2A};
      4: return {6'h00, 6'h04};
      5: return {6'h00, 6'h07};
      6: return {6'h00, 6'h00};
      7: return {6'h00, 6'h03};
      8: return {6'h00, 6'h02};
      9: return {6'h00, 6'h08};
      10: return {6'h00, 6'h10};
      11: return {6'h00, 6'h12};
      12: return {6'h00, 6'h0D};
      13: return {6'h00, 6'h13};
      14: return {6'h02, 6'h15};  // Funct bits belong to the j target
      15: return {6'h00, 6'h3F};
      default: return {6'h23, 6'h20};
    endcase
  endfunction

  function automatic string instrName(input logic [5:0] op, input logic [5:0] fn);
    if (op == 6'h02) return "j";
    if (op != 6'h00) return "unknownOp";
    case (fn)
      6'h20: return "add";
      6'h24: return "and";
      6'h22: return "sub";
      6'h2A: return "slt";
      6'h04: return "sllv";
      6'h07: return "srav";
      6'h00: return "sll";
      6'h03: return "sra";
      6'h02: return "srl";
      6'h08: return "jr";
      6'h10: return "mfhi";
      6'h12: return "mflo";
      6'h0D: return "break";
      6'h13: return "rte";
      default: return "unknownFunct";
    endcase
  endfunction

  function automatic trace_t expectedTrace(input logic [5:0] op, input logic [5:0] fn);
    trace_t t;
    t = '{len: 0, aluR: -1, aluOp: 4'd0, regR: -1, wds: 3'd0, pcR: 2, pcSrc: 2'd1};
    if (op == 6'h02) begin
      t.pcSrc = 2'd2;
    end else if (op == 6'h00) begin
      case (fn)
        6'h20, 6'h24, 6'h22, 6'h2A, 6'h00, 6'h03, 6'h02: begin
          t.len = 5;
          t.aluR = 4;
          t.regR = 5;
          case (fn)
            6'h20: t.aluOp = 4'd1;
            6'h24: t.aluOp = 4'd3;
            6'h22: t.aluOp = 4'd2;
            6'h2A: t.aluOp = 4'd10;
            6'h00: t.aluOp = 4'd5;
            6'h03: t.aluOp = 4'd8;
            default: t.aluOp = 4'd7;
          endcase
        end
        6'h04, 6'h07: begin  // Variable shifts hold one cycle longer
          t.len = 6;
          t.aluR = 4;
          t.regR = 6;
          t.aluOp = (fn == 6'h04) ? 4'd6 : 4'd9;
        end
        6'h08: begin
          t.len = 5;
          t.aluR = 4;
          t.pcR = 5;
          t.pcSrc = 2'd0;
        end
        6'h13: begin
          t.len = 2;
          t.pcR = 3;
          t.pcSrc = 2'd3;
        end
        6'h10, 6'h12: begin
          t.len = 2;
          t.regR = 2;
          t.wds = (fn == 6'h10) ? 3'd3 : 3'd4;
        end
        6'h0D: begin
          t.len = 5;
          t.aluR = 3;
          t.aluOp = 4'd2;
          t.pcR = 5;
        end
        default: ;
      endcase
    end
    return t;
  endfunction

  initial begin : driveStimulus
    logic [11:0] instr;
    logic [21:0] controlWord;
    int cnt;
    logic aborted;
    aborted = 1'b0;
    lfsr = lfsrSeed;
    reset_in <= 1'b1;
    opcode <= 6'h3F;
    funct <= 6'h00;
    @(posedge clk);
    @(posedge clk);
    controlWord = {pcWrite, irWrite, aluOutWrite, regFileWrite, aRegWrite, bRegWrite,
                   pcSource, aluSrcA, aluSrcB, regDst, writeDataSel, aluOp};
    assert (resetOut === 1'b1 && controlWord === '0)
    else begin
      $display("Fail reset resetOut/controls expected 1/0 actual %0d/%0h",
               resetOut, controlWord);
      failCount++;
    end
    reset_in <= 1'b0;
    cnt = 0;
    do begin
      @(posedge clk);
      cnt++;
    end while (!irWrite && cnt < 10);
    // Sampled one edge after irWrite rose
    assert (irWrite && cnt - 1 == 2) else begin
      $display("Fail reset expected %0d actual %0d", 2, cnt - 1);
      failCount++;
      aborted = 1'b1;
    end
    assert (resetOut === 1'b0) else begin
      $display("Fail reset resetOut after release expected 0 actual %0d", resetOut);
      failCount++;
    end
    $display("test reset: %s", (failCount == 0) ? "ok" : "FAILED");
    for (int n = 0; n <= numTests && !aborted; n++) begin
      if (n > 0) begin
        cnt = 0;
        do begin
          @(posedge clk);
          cnt++;
        end while (!irWrite && cnt < 12);
        if (!irWrite) begin
          $display("Error: irWrite stopped while driving instruction %0d", n);
          failCount++;
          aborted = 1'b1;
        end
      end
      if (!aborted) begin
        instr = (n < numTests) ? pickInstr(int'(takeBits(5) % 17)) : {6'h3F, 6'h00};
        opcode <= instr[11:6];
        funct <= instr[5:0];
      end
    end
    cnt = 0;
    while (!checksDone && cnt < 200) begin
      @(posedge clk);
      cnt++;
    end
    if (!checksDone) begin
      $display("Error: checker did not finish in time");
      failCount++;
    end
    $display("tests %0d, failures %0d", testCount, failCount);
    if (failCount == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin : compareOutputs
    trace_t exp;
    string name;
    int r;
    int waitCount;
    int regR;
    int regCount;
    int pcR;
    int failsBefore;
    logic [2:0] wdsSeen;
    logic [1:0] dstSeen;
    logic [1:0] pcSrcSeen;
    logic [3:0] aluSeen;
    waitCount = 0;
    do begin
      @(posedge clk);
      waitCount++;
    end while (!irWrite && waitCount < 40);
    if (!irWrite) begin
      $display("Error: first irWrite never arrived");
      failCount++;
    end else begin
      for (int n = 0; n < numTests; n++) begin
        exp = expectedTrace(6'h3F, 6'h00);
        name = "none";
        r = 0;
        regR = -1;
        regCount = 0;
        pcR = -1;
        wdsSeen = '0;
        dstSeen = '0;
        pcSrcSeen = '0;
        aluSeen = '0;
        failsBefore = failCount;
        do begin
          @(posedge clk);
          r++;
          if (!irWrite) begin
            if (r == 1) begin  // Inputs now hold this instruction
              exp = expectedTrace(opcode, funct);
              name = instrName(opcode, funct);
            end
            if (regFileWrite) begin
              regCount++;
              if (regR < 0) begin
                regR = r;
                wdsSeen = writeDataSel;
                dstSeen = regDst;
              end
            end
            if (pcWrite) begin
              pcR = r;
              pcSrcSeen = pcSource;
            end
            if (r == exp.aluR) aluSeen = aluOp;
          end
        end while (!irWrite && r < 12);
        if (!irWrite) begin
          $display("Error: %s never returned to fetch", name);
          failCount++;
          break;
        end
        assert (r == 3 + exp.len) else begin
          $display("Fail %s gap expected %0d actual %0d", name, 3 + exp.len, r);
          failCount++;
        end
        assert (regR == exp.regR && regCount == (exp.regR < 0 ? 0 : 1)) else begin
          $display("Fail %s regFileWrite cycle expected %0d actual %0d (%0d writes)",
                   name, exp.regR, regR, regCount);
          failCount++;
        end
        if (exp.regR >= 0) begin
          assert (wdsSeen == exp.wds && dstSeen == 2'd1) else begin
            $display("Fail %s writeDataSel/regDst expected %0d/1 actual %0d/%0d",
                     name, exp.wds, wdsSeen, dstSeen);
            failCount++;
          end
        end
        assert (pcR == exp.pcR && pcSrcSeen == exp.pcSrc) else begin
          $display("Fail %s pcWrite cycle/pcSource expected %0d/%0d actual %0d/%0d",
                   name, exp.pcR, exp.pcSrc, pcR, pcSrcSeen);
          failCount++;
        end
        if (exp.aluR >= 0) begin
          assert (aluSeen == exp.aluOp) else begin
            $display("Fail %s aluOp expected %0d actual %0d", name, exp.aluOp, aluSeen);
            failCount++;
          end
        end
        testCount++;
        $display("test %0d %s: %s", n, name, (failCount == failsBefore) ? "ok" : "FAILED");
      end
    end
    checksDone = 1'b1;
  end

endmodule

`default_nettype wire

//--- build.f
common/isaPkg.sv
common/controlPkg.sv
common/decodeIf.sv
hdl/instrDecoder.sv
sequencer/stepCounter.sv
sequencer/cycleSequencer.sv
hdl/controlEncoder.sv
hdl/controlUnit.sv
verif/controlUnitProperties.sv
verif/controlUnitTb.sv

//--- run.sh
#!/bin/sh
# Compile and run the control unit testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f build.f --top-module controlUnitTb -Mdir obj_dir

./obj_dir/VcontrolUnitTb > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation completed successfully" sim.log; then
  exit 0
else
  exit 1
fi
